//--- Makefile
# Verilator build and run of the fetch subsystem testbench.
# Any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_rv_fetch_subsystem
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_TEXT ?= Checks failed
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "test FAILED, run ended early, see $(LOG)"; exit 1; \
	else \
		echo "test PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- list.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_bus_pkg.sv
source/rv_fetch_queue.sv
source/rv_fetch.sv
source/rv_bus_arbiter.sv
source/rv_imem.sv
source/rv_fetch_subsystem.sv
testbench/tb_rv_fetch_subsystem.sv

//--- source/rv_bus_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module rv_bus_arbiter
    import rv_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_m0_cyc,
    input  logic     i_m0_stb,
    input  logic     i_m0_we,
    input  rv_addr_t i_m0_addr,
    input  rv_word_t i_m0_wdata,
    output logic     o_m0_ack,
    output rv_word_t o_m0_rdata,
    input  logic     i_m1_cyc,
    input  logic     i_m1_stb,
    input  logic     i_m1_we,
    input  rv_addr_t i_m1_addr,
    input  rv_word_t i_m1_wdata,
    output logic     o_m1_ack,
    output rv_word_t o_m1_rdata,
    output logic     o_s_cyc,
    output logic     o_s_stb,
    output logic     o_s_we,
    output rv_addr_t o_s_addr,
    output rv_word_t o_s_wdata,
    input  logic     i_s_ack,
    input  rv_word_t i_s_rdata
);

    rv_arb_state_e state;
    rv_arb_state_e state_next;
    rv_master_e    last_owner;

    // every grant passes through idle, so the fairness decision lives in one place.
    always_comb
    begin
        state_next = state;
        case (state)
            ARB_IDLE:
            begin
                if (i_m0_cyc && i_m1_cyc)
                    state_next = (last_owner == MST_FETCH) ? ARB_DATA : ARB_FETCH;
                else if (i_m0_cyc)
                    state_next = ARB_FETCH;
                else if (i_m1_cyc)
                    state_next = ARB_DATA;
            end
            ARB_FETCH: if (!i_m0_cyc) state_next = ARB_IDLE;  // released at end of access.
            ARB_DATA:  if (!i_m1_cyc) state_next = ARB_IDLE;
            default:   state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state      <= ARB_IDLE;
            last_owner <= MST_DATA;  // fetch wins the first tie.
        end
        else
        begin
            state <= state_next;
            if (state == ARB_IDLE && state_next == ARB_FETCH)
                last_owner <= MST_FETCH;
            else if (state == ARB_IDLE && state_next == ARB_DATA)
                last_owner <= MST_DATA;
        end
    end

    // the owner's signals go straight to the slave, nothing is driven when idle.
    always_comb
    begin
        o_s_cyc   = 1'b0;
        o_s_stb   = 1'b0;
        o_s_we    = 1'b0;
        o_s_addr  = i_m0_addr;
        o_s_wdata = i_m0_wdata;
        case (state)
            ARB_FETCH:
            begin
                o_s_cyc = i_m0_cyc;
                o_s_stb = i_m0_stb;
                o_s_we  = i_m0_we;
            end
            ARB_DATA:
            begin
                o_s_cyc   = i_m1_cyc;
                o_s_stb   = i_m1_stb;
                o_s_we    = i_m1_we;
                o_s_addr  = i_m1_addr;
                o_s_wdata = i_m1_wdata;
            end
            default: ;
        endcase
    end

    assign o_m0_ack   = (state == ARB_FETCH) && i_s_ack;
    assign o_m1_ack   = (state == ARB_DATA) && i_s_ack;
    assign o_m0_rdata = i_s_rdata;  // data is only meaningful together with ack.
    assign o_m1_rdata = i_s_rdata;

    // an ack from memory lands only on a master that is still requesting.
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_m0_ack |-> (i_m0_cyc && i_m0_stb))
        else $error("ack sent to idle fetch master");
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_m1_ack |-> (i_m1_cyc && i_m1_stb))
        else $error("ack sent to idle data master");

endmodule

`default_nettype wire

//--- source/rv_bus_pkg.sv
`default_nettype none

`include "rv_fetch_macros.svh"

package rv_bus_pkg;

    typedef logic [`RV_IADDR_BITS-1:0] rv_addr_t;  // byte address on the bus.
    typedef logic [31:0]               rv_word_t;  // full-word data, no byte lanes.

    // who currently holds the shared bus.
    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_FETCH = 2'd1,
        ARB_DATA  = 2'd2
    } rv_arb_state_e;

    // which master won the last arbitration round.
    typedef enum logic {
        MST_FETCH = 1'b0,
        MST_DATA  = 1'b1
    } rv_master_e;

endpackage

`default_nettype wire

//--- source/rv_fetch.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_fetch_macros.svh"

module rv_fetch
    import rv_isa_pkg::*;
(
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_stall,
    input  logic                      i_flush,
    input  logic                      i_pc_select,
    input  logic [`RV_IADDR_BITS-1:0] i_pc_target,
    input  logic                      i_ebreak,
    input  logic [`RV_IADDR_BITS-1:0] i_pc_trap,
    input  logic                      i_ack,
    input  rv_instr_t                 i_rdata,
    output logic                      o_cyc,
    output logic                      o_stb,
    output logic [`RV_IADDR_BITS-1:0] o_addr,
    output rv_instr_t                 o_instruction,
    output logic [`RV_IADDR_BITS-1:0] o_pc,
    output logic                      o_branch_pred,
    output logic                      o_ready
);

    logic [`RV_IADDR_BITS-1:0]               pc;        // next address to fetch.
    logic [`RV_IADDR_BITS-1:0]               req_addr;  // address of the access on the bus.
    logic [`RV_IADDR_BITS-1:0]               pc_jump;
    logic                                    cyc;
    logic                                    discard;
    logic                                    redirect;
    logic                                    accept;
    logic                                    push_q;
    logic [`RV_IADDR_BITS+RV_INSTR_BITS-1:0] push_data;
    logic [`RV_IADDR_BITS+RV_INSTR_BITS-1:0] pop_data;
    logic                                    q_empty;
    logic                                    q_full;
    logic                                    q_pop;
    rv_opcode_e                              opcode;

    // trap beats redirect, redirect beats sequential.
    assign redirect = i_ebreak || i_pc_select;
    assign pc_jump  = i_ebreak ? i_pc_trap : i_pc_target;

    // an ack is dropped if its access was overtaken by a redirect, now or earlier.
    assign accept = i_ack && !redirect && !discard && !q_full;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            pc      <= `RV_RESET_ADDR;
            cyc     <= 1'b0;
            discard <= 1'b0;
            push_q  <= 1'b0;
        end
        else
        begin
            if (redirect)
                pc <= pc_jump;
            else if (accept)
                pc <= pc + `RV_IADDR_BITS'(4);

            // one word per cyc period; a new request waits until the last word is queued.
            if (cyc && i_ack)
                cyc <= 1'b0;
            else if (!cyc && !push_q && !q_full && !redirect)
                cyc <= 1'b1;

            // the access in flight still has to finish, its data is thrown away.
            if (i_ack)
                discard <= 1'b0;
            else if (redirect && cyc)
                discard <= 1'b1;

            push_q <= accept;  // the word enters the queue one clock after its ack.
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!cyc)
            req_addr <= pc;  // follows the pc while idle and freezes for the access.
        if (accept)
            push_data <= {req_addr, i_rdata};
    end

    assign o_cyc  = cyc;
    assign o_stb  = cyc;
    assign o_addr = req_addr;

    assign q_pop = !q_empty && !i_stall;

    rv_fetch_queue u_queue
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_push  (push_q),
        .i_pop   (q_pop),
        .i_data  (push_data),
        .o_data  (pop_data),
        .o_empty (q_empty),
        .o_full  (q_full)
    );

    assign {o_pc, o_instruction} = pop_data;
    assign o_ready = !q_empty;

    // static prediction on the queue head.
    // a jal is always taken; a branch is taken when its offset points backward.
    assign opcode = rv_opcode_e'(o_instruction[RV_OPCODE_BITS-1:0]);
    assign o_branch_pred = (opcode == OP_JAL) ||
                           ((opcode == OP_BRANCH) && o_instruction[RV_IMM_SIGN_BIT]);

endmodule

`default_nettype wire

//--- source/rv_fetch_macros.svh
`ifndef RV_FETCH_MACROS_SVH
`define RV_FETCH_MACROS_SVH

// byte address width of the instruction side, 64 KiB of space.
`define RV_IADDR_BITS 16

// the program counter starts here after reset.
`define RV_RESET_ADDR 16'h0000

// log2 of the fetch queue depth, four entries.
`define RV_FQ_DEPTH_BITS 2

// log2 of the memory size in 32-bit words.
// with 256 words the word index is taken from address bits [9:2].
`define RV_MEM_WORDS_BITS 8

`endif

//--- source/rv_fetch_queue.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_fetch_macros.svh"

module rv_fetch_queue
    import rv_isa_pkg::*;
(
    input  logic                                    i_clk,
    input  logic                                    i_reset,
    input  logic                                    i_flush,
    input  logic                                    i_push,
    input  logic                                    i_pop,
    input  logic [`RV_IADDR_BITS+RV_INSTR_BITS-1:0] i_data,
    output logic [`RV_IADDR_BITS+RV_INSTR_BITS-1:0] o_data,
    output logic                                    o_empty,
    output logic                                    o_full
);

    localparam int DEPTH = 1 << `RV_FQ_DEPTH_BITS;

    logic [`RV_IADDR_BITS+RV_INSTR_BITS-1:0] mem [DEPTH];
    logic [`RV_FQ_DEPTH_BITS-1:0]            wr_ptr;
    logic [`RV_FQ_DEPTH_BITS-1:0]            rd_ptr;
    logic [`RV_FQ_DEPTH_BITS:0]              count;  // one extra bit so full and empty differ.
    logic                                    do_push;
    logic                                    do_pop;

    // a flush wins over a push arriving in the same cycle, so stale words never enter.
    assign do_push = i_push && !o_full && !i_flush;
    assign do_pop  = i_pop && !o_empty;

    assign o_empty = (count == '0);
    assign o_full  = count[`RV_FQ_DEPTH_BITS];  // only set when count equals DEPTH.
    assign o_data  = mem[rd_ptr];               // head is visible without a pop.

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // pointers wrap naturally at DEPTH.
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leave the level unchanged.
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= i_data;
    end

    // fetch must never offer a word the queue cannot take, nor pop an empty queue.
    assert property (@(posedge i_clk) disable iff (i_reset || i_flush)
        !(i_push && o_full) && !(i_pop && o_empty))
        else $error("fetch queue overflow or underflow");

endmodule

`default_nettype wire

//--- source/rv_fetch_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module rv_fetch_subsystem
    import rv_isa_pkg::*, rv_bus_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_stall,
    input  logic      i_flush,
    input  logic      i_pc_select,
    input  rv_addr_t  i_pc_target,
    input  logic      i_ebreak,
    input  rv_addr_t  i_pc_trap,
    output rv_instr_t o_instruction,
    output rv_addr_t  o_pc,
    output logic      o_branch_pred,
    output logic      o_ready,
    input  logic      i_d_cyc,
    input  logic      i_d_stb,
    input  logic      i_d_we,
    input  rv_addr_t  i_d_addr,
    input  rv_word_t  i_d_wdata,
    output logic      o_d_ack,
    output rv_word_t  o_d_rdata
);

    logic     f_cyc;  // fetch master side.
    logic     f_stb;
    rv_addr_t f_addr;
    logic     f_ack;
    rv_word_t f_rdata;
    logic     s_cyc;  // memory side, after the arbiter.
    logic     s_stb;
    logic     s_we;
    rv_addr_t s_addr;
    rv_word_t s_wdata;
    logic     s_ack;
    rv_word_t s_rdata;

    rv_fetch u_fetch
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_pc_select   (i_pc_select),
        .i_pc_target   (i_pc_target),
        .i_ebreak      (i_ebreak),
        .i_pc_trap     (i_pc_trap),
        .i_ack         (f_ack),
        .i_rdata       (f_rdata),
        .o_cyc         (f_cyc),
        .o_stb         (f_stb),
        .o_addr        (f_addr),
        .o_instruction (o_instruction),
        .o_pc          (o_pc),
        .o_branch_pred (o_branch_pred),
        .o_ready       (o_ready)
    );

    // master 0 is fetch and only reads; master 1 is the external data port.
    rv_bus_arbiter u_arbiter
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_m0_cyc   (f_cyc),
        .i_m0_stb   (f_stb),
        .i_m0_we    (1'b0),
        .i_m0_addr  (f_addr),
        .i_m0_wdata ('0),
        .o_m0_ack   (f_ack),
        .o_m0_rdata (f_rdata),
        .i_m1_cyc   (i_d_cyc),
        .i_m1_stb   (i_d_stb),
        .i_m1_we    (i_d_we),
        .i_m1_addr  (i_d_addr),
        .i_m1_wdata (i_d_wdata),
        .o_m1_ack   (o_d_ack),
        .o_m1_rdata (o_d_rdata),
        .o_s_cyc    (s_cyc),
        .o_s_stb    (s_stb),
        .o_s_we     (s_we),
        .o_s_addr   (s_addr),
        .o_s_wdata  (s_wdata),
        .i_s_ack    (s_ack),
        .i_s_rdata  (s_rdata)
    );

    rv_imem u_imem
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_cyc   (s_cyc),
        .i_stb   (s_stb),
        .i_we    (s_we),
        .i_addr  (s_addr),
        .i_wdata (s_wdata),
        .o_ack   (s_ack),
        .o_rdata (s_rdata)
    );

endmodule

`default_nettype wire

//--- source/rv_imem.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_fetch_macros.svh"

module rv_imem
    import rv_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  logic     i_cyc,
    input  logic     i_stb,
    input  logic     i_we,
    input  rv_addr_t i_addr,
    input  rv_word_t i_wdata,
    output logic     o_ack,
    output rv_word_t o_rdata
);

    localparam int WORDS = 1 << `RV_MEM_WORDS_BITS;

    rv_word_t                      mem [WORDS];
    logic [`RV_MEM_WORDS_BITS-1:0] index;
    logic                          request;

    // word addressed, the two byte bits are ignored.
    assign index   = i_addr[`RV_MEM_WORDS_BITS+1:2];
    assign request = i_cyc && i_stb;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
            o_ack <= 1'b0;
        else
            o_ack <= request && !o_ack;  // single pulse, one clock after the request.
    end

    // read data is captured on the same edge that raises ack.
    always_ff @(posedge i_clk)
    begin
        if (request && !o_ack)
            o_rdata <= mem[index];
    end

    // writes land at the end of the ack cycle while address and data are still held.
    always_ff @(posedge i_clk)
    begin
        if (request && o_ack && i_we)
            mem[index] <= i_wdata;
    end

    // ack never stretches over two cycles.
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_ack |=> !o_ack)
        else $error("memory ack held for two cycles");

    // whichever master was served has let go of stb the cycle after its ack.
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_ack |=> !request)
        else $error("master kept stb after ack");

endmodule

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int RV_INSTR_BITS   = 32;  // uncompressed instructions only.
    localparam int RV_OPCODE_BITS  = 7;   // major opcode sits in bits [6:0].
    localparam int RV_IMM_SIGN_BIT = 31;  // every immediate format keeps its sign here.

    // one raw instruction word as it comes off the bus.
    typedef logic [RV_INSTR_BITS-1:0] rv_instr_t;

    // major opcodes of RV32I.
    // the two low bits are always 2'b11 for 32-bit encodings.
    typedef enum logic [RV_OPCODE_BITS-1:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,  // unconditional, always taken.
        OP_JALR   = 7'b1100111,  // target comes from a register, not predicted here.
        OP_BRANCH = 7'b1100011,  // conditional branches share this opcode.
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011   // ecall, ebreak and the csr group.
    } rv_opcode_e;

endpackage

`default_nettype wire

//--- testbench/rv_fetch_stim.txt
# W addr data | R addr expected | G count | J target count | F count
# T vector target count ; every field is hex, counts are instructions consumed
W 000 00100093
W 004 12345137
W 008 0100006F
W 00C FE208CE3
W 010 00209463
W 014 00008067
W 018 00000297
W 01C 0000A183
W 020 0020A023
W 024 FFF00093
W 028 FF5FF06F
W 02C FE20CEE3
W 030 002081B3
W 034 00100073
W 100 00000013
W 104 FE0008E3
W 108 0000006F
W 10C 30200073
R 008 0100006F
R 02C FE20CEE3
R 104 FE0008E3
G 6
F 3
J 008 4
R 034 00100073
T 100 020 4
J 020 5

//--- testbench/tb_rv_fetch_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_fetch_macros.svh"

module tb_rv_fetch_subsystem;

    localparam string STIM_FILE     = "testbench/rv_fetch_stim.txt";
    localparam int    CLOCKS_PER_LINE = 200;
    localparam int    HOLD_CYCLES   = 32;         // long stall so the queue fills to the brim.
    localparam int    QUEUE_DEPTH   = 1 << `RV_FQ_DEPTH_BITS;
    localparam logic [6:0] JAL_OPCODE    = 7'b1101111;
    localparam logic [6:0] BRANCH_OPCODE = 7'b1100011;

    logic                      i_clk;
    logic                      i_reset;
    logic                      i_stall;
    logic                      i_flush;
    logic                      i_pc_select;
    logic [`RV_IADDR_BITS-1:0] i_pc_target;
    logic                      i_ebreak;
    logic [`RV_IADDR_BITS-1:0] i_pc_trap;
    logic [31:0]               o_instruction;
    logic [`RV_IADDR_BITS-1:0] o_pc;
    logic                      o_branch_pred;
    logic                      o_ready;
    logic                      i_d_cyc;
    logic                      i_d_stb;
    logic                      i_d_we;
    logic [`RV_IADDR_BITS-1:0] i_d_addr;
    logic [31:0]               i_d_wdata;
    logic                      o_d_ack;
    logic [31:0]               o_d_rdata;

    logic [31:0]               ref_mem [logic [`RV_IADDR_BITS-1:0]];  // program as written.
    logic [`RV_IADDR_BITS-1:0] last_pc;     // last address the consumer took.
    logic [15:0]               lfsr;
    logic [1023:0]             line_buf;
    int                        fd;
    int                        line_total;
    int                        check_count;
    int                        error_count;

    rv_fetch_subsystem UUT
    (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_pc_select   (i_pc_select),
        .i_pc_target   (i_pc_target),
        .i_ebreak      (i_ebreak),
        .i_pc_trap     (i_pc_trap),
        .o_instruction (o_instruction),
        .o_pc          (o_pc),
        .o_branch_pred (o_branch_pred),
        .o_ready       (o_ready),
        .i_d_cyc       (i_d_cyc),
        .i_d_stb       (i_d_stb),
        .i_d_we        (i_d_we),
        .i_d_addr      (i_d_addr),
        .i_d_wdata     (i_d_wdata),
        .o_d_ack       (o_d_ack),
        .o_d_rdata     (o_d_rdata)
    );

    always #5 i_clk = ~i_clk;  // 100 MHz.

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // static rule: every jal, and conditional branches whose offset is negative.
    function automatic logic predict_taken(input logic [31:0] instr);
        predict_taken = (instr[6:0] == JAL_OPCODE) ||
                        ((instr[6:0] == BRANCH_OPCODE) && instr[31]);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count = check_count + 1;
        assert (actual === expected)
        else
        begin
            error_count = error_count + 1;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // one wishbone classic cycle on the data port; the bus may be busy with fetch.
    task automatic bus_access(input logic we, input logic [`RV_IADDR_BITS-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        logic acked;
        acked = 1'b0;
        rdata = 32'd0;
        @(posedge i_clk);
        i_stall   <= 1'b0;  // fetch runs freely and competes for memory.
        i_d_cyc   <= 1'b1;
        i_d_stb   <= 1'b1;
        i_d_we    <= we;
        i_d_addr  <= addr;
        i_d_wdata <= wdata;
        while (!acked)
        begin
            @(negedge i_clk);
            if (o_d_ack)
            begin
                acked = 1'b1;
                rdata = o_d_rdata;  // read data is valid together with ack.
            end
        end
        @(posedge i_clk);
        i_d_cyc <= 1'b0;  // the cycle after ack ends the access.
        i_d_stb <= 1'b0;
        i_d_we  <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        i_reset <= 1'b1;
        i_stall <= 1'b1;
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
    endtask

    // one clock of flush, optionally with redirect and trap.
    task automatic pulse_control(input logic sel, input logic trap,
                                 input logic [`RV_IADDR_BITS-1:0] target,
                                 input logic [`RV_IADDR_BITS-1:0] vector);
        @(posedge i_clk);
        i_stall     <= 1'b1;
        i_flush     <= 1'b1;
        i_pc_select <= sel;
        i_pc_target <= target;
        i_ebreak    <= trap;
        i_pc_trap   <= vector;
        @(posedge i_clk);
        i_flush     <= 1'b0;
        i_pc_select <= 1'b0;
        i_ebreak    <= 1'b0;
    endtask

    // takes count entries under random stall and checks each against the model.
    task automatic consume_stream(input logic [15:0] count,
                                  input logic [`RV_IADDR_BITS-1:0] start_pc);
        logic [15:0]               got;
        logic [`RV_IADDR_BITS-1:0] exp_pc;
        logic [31:0]               exp_instr;
        got    = 16'd0;
        exp_pc = start_pc;
        repeat (HOLD_CYCLES) @(posedge i_clk);
        while (got < count)
        begin
            lfsr = lfsr_next(lfsr);  // one step per stall bit.
            i_stall <= lfsr[0];
            @(negedge i_clk);
            if (o_ready && !i_stall)
            begin
                assert (ref_mem.exists(exp_pc))
                else
                begin
                    error_count = error_count + 1;
                    $display("stimulus error, no program word at %h", exp_pc);
                end
                exp_instr = ref_mem.exists(exp_pc) ? ref_mem[exp_pc] : 32'd0;
                check_value(32'(o_pc), 32'(exp_pc), "fetch pc");
                check_value(o_instruction, exp_instr, "instruction");
                check_value(32'(o_branch_pred), 32'(predict_taken(exp_instr)),
                            "branch prediction");
                last_pc = exp_pc;
                exp_pc  = exp_pc + `RV_IADDR_BITS'(4);  // strictly sequential between redirects.
                got     = got + 16'd1;
            end
            @(posedge i_clk);
        end
        i_stall <= 1'b1;
    endtask

    task automatic run_command(input logic [7:0] cmd);
        logic [`RV_IADDR_BITS-1:0] addr_arg;
        logic [`RV_IADDR_BITS-1:0] vector_arg;
        logic [15:0]               count_arg;
        logic [31:0]               data_arg;
        logic [31:0]               read_data;
        int                        code;
        case (cmd)
            "#": code = $fgets(line_buf, fd);  // column description, skipped.
            "W":
            begin
                code = $fscanf(fd, "%h %h", addr_arg, data_arg);
                bus_access(1'b1, addr_arg, data_arg, read_data);
                ref_mem[addr_arg] = data_arg;
            end
            "R":
            begin
                code = $fscanf(fd, "%h %h", addr_arg, data_arg);
                bus_access(1'b0, addr_arg, 32'd0, read_data);
                check_value(read_data, data_arg, "data port read");
            end
            "G":
            begin
                code = $fscanf(fd, "%h", count_arg);
                apply_reset();
                consume_stream(count_arg, `RV_RESET_ADDR);
            end
            "J":
            begin
                code = $fscanf(fd, "%h %h", addr_arg, count_arg);
                pulse_control(1'b1, 1'b0, addr_arg, '0);
                consume_stream(count_arg, addr_arg);
            end
            "T":
            begin
                // redirect is raised too, the trap vector has to win.
                code = $fscanf(fd, "%h %h %h", vector_arg, addr_arg, count_arg);
                pulse_control(1'b1, 1'b1, addr_arg, vector_arg);
                consume_stream(count_arg, vector_arg);
            end
            "F":
            begin
                // the full queue holds the words right after the last one taken.
                // fetch stopped past them, so the stream resumes a whole queue further on.
                code = $fscanf(fd, "%h", count_arg);
                repeat (HOLD_CYCLES) @(posedge i_clk);
                pulse_control(1'b0, 1'b0, '0, '0);
                consume_stream(count_arg, last_pc + `RV_IADDR_BITS'(4 * (QUEUE_DEPTH + 1)));
            end
            default:
            begin
                error_count = error_count + 1;
                $display("stimulus file holds an unknown command '%c'", cmd);
            end
        endcase
    endtask

    initial
    begin
        wait (line_total > 0);
        repeat (line_total * CLOCKS_PER_LINE) @(posedge i_clk);
        $display("run timed out after %0d clocks, %0d errors so far",
                 line_total * CLOCKS_PER_LINE, error_count);
        $display("Checks failed");
        $finish;
    end

    initial
    begin
        int          lines;
        int          code;
        logic [7:0]  cmd;
        logic        done;
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_stall     = 1'b1;
        i_flush     = 1'b0;
        i_pc_select = 1'b0;
        i_pc_target = '0;
        i_ebreak    = 1'b0;
        i_pc_trap   = '0;
        i_d_cyc     = 1'b0;
        i_d_stb     = 1'b0;
        i_d_we      = 1'b0;
        i_d_addr    = '0;
        i_d_wdata   = '0;
        lfsr        = 16'd68;
        last_pc     = '0;
        line_total  = 0;
        check_count = 0;
        error_count = 0;
        lines       = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("stimulus file %s could not be opened", STIM_FILE);
            $display("Checks failed");
            $finish;
        end
        else
        begin
            while ($fgets(line_buf, fd) != 0)
                lines = lines + 1;
            $fclose(fd);
            line_total = lines;  // set once, so the watchdog sees the full length.
            fd = $fopen(STIM_FILE, "r");
            repeat (3) @(posedge i_clk);
            i_reset <= 1'b0;
            done = 1'b0;
            while (!done)
            begin
                code = $fscanf(fd, " %c", cmd);
                if (code != 1)
                    done = 1'b1;
                else
                    run_command(cmd);
            end
            $fclose(fd);
            repeat (2) @(posedge i_clk);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0)
                $display("All checks passed");
            else
                $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire
